/* build.f */
cdc_pkg.sv
cdc_src_half.sv
cdc_dst_half.sv
resp_err_counter.sv
master_port.sv
core_cdc_wrap.sv
core_cdc_chk.sv
tb_checker.sv
tb_top.sv

/* cdc_dst_half.sv */
// Read half of a gray-pointer async FIFO; pops far-domain entries one per cycle with a valid strobe
`timescale 1ns/1ps

module cdc_dst_half #(
  parameter int unsigned LOG_DEPTH = 2,
  parameter type         payload_t = cdc_pkg::rsp_t
) (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic [LOG_DEPTH:0]                           wptr_i,
  input  logic [(2**LOG_DEPTH)*$bits(payload_t)-1:0]   data_i,
  output logic [LOG_DEPTH:0]                           rptr_o,
  output logic                                         pop_valid_o,
  output payload_t                                     payload_o
);
  import cdc_pkg::*;

  localparam int unsigned DEPTH     = 2**LOG_DEPTH;
  localparam int unsigned PAYLOAD_W = $bits(payload_t);

  typedef logic [LOG_DEPTH:0] ptr_t;

  payload_t entries [DEPTH];
  ptr_t     wptr_meta_q;
  ptr_t     wptr_sync_q;
  ptr_t     rbin_q;
  ptr_t     rgray_q;
  ptr_t     rbin_next;
  logic     pop;
  logic     valid_q;
  payload_t payload_q;

  // Unflatten the far storage
  for (genvar k = 0; k < DEPTH; k++) begin : g_unflat
    assign entries[k] = payload_t'(data_i[k*PAYLOAD_W +: PAYLOAD_W]);
  end

  // ******************************
  // Far write pointer synchronizer
  // ******************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wptr_meta_q <= '0;
      wptr_sync_q <= '0;
    end else begin
      wptr_meta_q <= wptr_i;
      wptr_sync_q <= wptr_meta_q;
    end
  end

  // Not empty means at least one entry to take
  assign pop       = (wptr_sync_q != rgray_q);
  assign rbin_next = rbin_q + ptr_t'(1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rbin_q  <= '0;
      rgray_q <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= pop;
      if (pop) begin
        rbin_q  <= rbin_next;
        rgray_q <= ptr_t'(bin2gray(32'(rbin_next)));
      end
    end
  end

  // Popped entry qualified by valid_q
  always_ff @(posedge clk_i) begin
    if (pop) begin
      payload_q <= entries[rbin_q[LOG_DEPTH-1:0]];
    end
  end

  assign rptr_o      = rgray_q;
  assign pop_valid_o = valid_q;
  assign payload_o   = payload_q;

endmodule

/* cdc_pkg.sv */
// Shared widths, request/response payload types, AXI response codes and gray-code helpers
package cdc_pkg;

  // ******************************
  // Widths
  // ******************************
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned ID_W      = 4;
  localparam int unsigned RESP_W    = 2;
  localparam int unsigned ERR_CNT_W = 8;

  // Combined request word of 69 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              we;
    logic [ID_W-1:0]   id;
  } req_t;

  // Combined response word of 38 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] rdata;
    logic [RESP_W-1:0] resp;
  } rsp_t;

  // AXI response encodings
  localparam logic [RESP_W-1:0] RESP_OKAY   = RESP_W'(0);
  localparam logic [RESP_W-1:0] RESP_EXOKAY = RESP_W'(1);
  localparam logic [RESP_W-1:0] RESP_SLVERR = RESP_W'(2);
  localparam logic [RESP_W-1:0] RESP_DECERR = RESP_W'(3);

  // ******************************
  // Gray helpers that callers truncate to pointer width
  // ******************************
  function automatic logic [31:0] bin2gray(input logic [31:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [31:0] gray2bin(input logic [31:0] gray);
    logic [31:0] bin;
    bin = gray;
    for (int i = 30; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* cdc_src_half.sv */
// Write half of a gray-pointer async FIFO; exposes storage and write pointer to the far domain
`timescale 1ns/1ps

module cdc_src_half #(
  parameter int unsigned LOG_DEPTH = 2,
  parameter type         payload_t = cdc_pkg::req_t
) (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         push_i,
  input  payload_t                                     payload_i,
  output logic [LOG_DEPTH:0]                           wptr_o,
  output logic [(2**LOG_DEPTH)*$bits(payload_t)-1:0]   data_o,
  input  logic [LOG_DEPTH:0]                           rptr_i,
  output logic                                         overflow_o
);
  import cdc_pkg::*;

  localparam int unsigned DEPTH     = 2**LOG_DEPTH;
  localparam int unsigned PAYLOAD_W = $bits(payload_t);

  typedef logic [LOG_DEPTH:0] ptr_t;

  payload_t mem_q [DEPTH];
  ptr_t     wbin_q;
  ptr_t     wgray_q;
  ptr_t     wbin_next;
  ptr_t     rptr_meta_q;
  ptr_t     rptr_sync_q;
  ptr_t     rbin_sync;
  logic     full;
  logic     accept;
  logic     overflow_q;

  // ******************************
  // Far read pointer synchronizer
  // ******************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rptr_meta_q <= '0;
      rptr_sync_q <= '0;
    end else begin
      rptr_meta_q <= rptr_i;
      rptr_sync_q <= rptr_meta_q;
    end
  end

  // Full when the wrap bits differ and the index bits match
  assign rbin_sync = ptr_t'(gray2bin(32'(rptr_sync_q)));
  assign full      = (wbin_q[LOG_DEPTH] != rbin_sync[LOG_DEPTH]) &&
                     (wbin_q[LOG_DEPTH-1:0] == rbin_sync[LOG_DEPTH-1:0]);
  assign accept    = push_i && !full;
  assign wbin_next = wbin_q + ptr_t'(1);

  // ******************************
  // Write pointer and overflow
  // ******************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wbin_q     <= '0;
      wgray_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (accept) begin
        wbin_q  <= wbin_next;
        wgray_q <= ptr_t'(bin2gray(32'(wbin_next)));
      end
      // Sticky until reset
      if (push_i && full) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[wbin_q[LOG_DEPTH-1:0]] <= payload_i;
    end
  end

  // Entry 0 sits in the low bits
  for (genvar k = 0; k < DEPTH; k++) begin : g_flat
    assign data_o[k*PAYLOAD_W +: PAYLOAD_W] = mem_q[k];
  end

  assign wptr_o     = wgray_q;
  assign overflow_o = overflow_q;

endmodule

/* core_cdc_chk.sv */
// Pointer and flag assertions bound into every master port
`timescale 1ns/1ps

module core_cdc_chk #(
  parameter int unsigned LOG_DEPTH = 2
) (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic [LOG_DEPTH:0] req_wptr_o,
  input logic [LOG_DEPTH:0] req_rptr_i,
  input logic [LOG_DEPTH:0] rsp_wptr_i,
  input logic [LOG_DEPTH:0] rsp_rptr_o,
  input logic               rsp_valid_o,
  input logic               overflow_o
);

  int unsigned fail_cnt = 0;

  // At most one gray step per cycle
  a_req_wptr_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $countones(req_wptr_o ^ $past(req_wptr_o)) <= 1)
    else begin
      $error("req_wptr_o jumped");
      fail_cnt++;
    end
  a_req_rptr_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $countones(req_rptr_i ^ $past(req_rptr_i)) <= 1)
    else begin
      $error("req_rptr_i jumped");
      fail_cnt++;
    end
  a_rsp_wptr_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $countones(rsp_wptr_i ^ $past(rsp_wptr_i)) <= 1)
    else begin
      $error("rsp_wptr_i jumped");
      fail_cnt++;
    end
  a_rsp_rptr_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $countones(rsp_rptr_o ^ $past(rsp_rptr_o)) <= 1)
    else begin
      $error("rsp_rptr_o jumped");
      fail_cnt++;
    end

  // Synchronized write pointer lags the far one by two edges
  a_rsp_valid_nonempty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |-> ($past(rsp_wptr_i, 3) != $past(rsp_rptr_o)))
    else begin
      $error("rsp_valid_o while FIFO empty");
      fail_cnt++;
    end

  a_overflow_sticky: assert property (@(posedge clk_i)
    $fell(overflow_o) |-> $past(!rst_n_i))
    else begin
      $error("overflow_o cleared without reset");
      fail_cnt++;
    end

endmodule

bind master_port core_cdc_chk #(
  .LOG_DEPTH ( LOG_DEPTH )
) u_chk (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .req_wptr_o  ( req_wptr_o  ),
  .req_rptr_i  ( req_rptr_i  ),
  .rsp_wptr_i  ( rsp_wptr_i  ),
  .rsp_rptr_o  ( rsp_rptr_o  ),
  .rsp_valid_o ( rsp_valid_o ),
  .overflow_o  ( overflow_o  )
);

/* core_cdc_wrap.sv */
// Core-side CDC top level with the data and cfi master ports exposed as loose gray-pointer FIFO ports
`timescale 1ns/1ps

module core_cdc_wrap #(
  parameter int unsigned LOG_DEPTH  = 2,
  localparam int unsigned REQ_DATA_W = (2**LOG_DEPTH)*$bits(cdc_pkg::req_t),
  localparam int unsigned RSP_DATA_W = (2**LOG_DEPTH)*$bits(cdc_pkg::rsp_t)
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // ******************************
  // Data master
  // ******************************
  input  logic                          data_req_valid_i,
  input  cdc_pkg::req_t                 data_req_i,
  output logic                          data_rsp_valid_o,
  output cdc_pkg::rsp_t                 data_rsp_o,
  output logic [LOG_DEPTH:0]            data_req_wptr_o,
  output logic [REQ_DATA_W-1:0]         data_req_data_o,
  input  logic [LOG_DEPTH:0]            data_req_rptr_i,
  input  logic [LOG_DEPTH:0]            data_rsp_wptr_i,
  input  logic [RSP_DATA_W-1:0]         data_rsp_data_i,
  output logic [LOG_DEPTH:0]            data_rsp_rptr_o,
  output logic                          data_overflow_o,
  output logic [cdc_pkg::ERR_CNT_W-1:0] data_err_cnt_o,

  // ******************************
  // CFI master
  // ******************************
  input  logic                          cfi_req_valid_i,
  input  cdc_pkg::req_t                 cfi_req_i,
  output logic                          cfi_rsp_valid_o,
  output cdc_pkg::rsp_t                 cfi_rsp_o,
  output logic [LOG_DEPTH:0]            cfi_req_wptr_o,
  output logic [REQ_DATA_W-1:0]         cfi_req_data_o,
  input  logic [LOG_DEPTH:0]            cfi_req_rptr_i,
  input  logic [LOG_DEPTH:0]            cfi_rsp_wptr_i,
  input  logic [RSP_DATA_W-1:0]         cfi_rsp_data_i,
  output logic [LOG_DEPTH:0]            cfi_rsp_rptr_o,
  output logic                          cfi_overflow_o,
  output logic [cdc_pkg::ERR_CNT_W-1:0] cfi_err_cnt_o
);

  master_port #(
    .LOG_DEPTH ( LOG_DEPTH )
  ) data_port (
    .clk_i       ( clk_i            ),
    .rst_n_i     ( rst_n_i          ),
    .req_valid_i ( data_req_valid_i ),
    .req_i       ( data_req_i       ),
    .rsp_valid_o ( data_rsp_valid_o ),
    .rsp_o       ( data_rsp_o       ),
    .req_wptr_o  ( data_req_wptr_o  ),
    .req_data_o  ( data_req_data_o  ),
    .req_rptr_i  ( data_req_rptr_i  ),
    .rsp_wptr_i  ( data_rsp_wptr_i  ),
    .rsp_data_i  ( data_rsp_data_i  ),
    .rsp_rptr_o  ( data_rsp_rptr_o  ),
    .overflow_o  ( data_overflow_o  ),
    .err_cnt_o   ( data_err_cnt_o   )
  );

  // Second crossing independent of the data port
  master_port #(
    .LOG_DEPTH ( LOG_DEPTH )
  ) cfi_port (
    .clk_i       ( clk_i           ),
    .rst_n_i     ( rst_n_i         ),
    .req_valid_i ( cfi_req_valid_i ),
    .req_i       ( cfi_req_i       ),
    .rsp_valid_o ( cfi_rsp_valid_o ),
    .rsp_o       ( cfi_rsp_o       ),
    .req_wptr_o  ( cfi_req_wptr_o  ),
    .req_data_o  ( cfi_req_data_o  ),
    .req_rptr_i  ( cfi_req_rptr_i  ),
    .rsp_wptr_i  ( cfi_rsp_wptr_i  ),
    .rsp_data_i  ( cfi_rsp_data_i  ),
    .rsp_rptr_o  ( cfi_rsp_rptr_o  ),
    .overflow_o  ( cfi_overflow_o  ),
    .err_cnt_o   ( cfi_err_cnt_o   )
  );

endmodule

/* master_port.sv */
// One core master crossing with request FIFO write half, response FIFO read half and error counter
`timescale 1ns/1ps

module master_port #(
  parameter int unsigned LOG_DEPTH  = 2,
  localparam int unsigned REQ_DATA_W = (2**LOG_DEPTH)*$bits(cdc_pkg::req_t),
  localparam int unsigned RSP_DATA_W = (2**LOG_DEPTH)*$bits(cdc_pkg::rsp_t)
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Core side
  input  logic                          req_valid_i,
  input  cdc_pkg::req_t                 req_i,
  output logic                          rsp_valid_o,
  output cdc_pkg::rsp_t                 rsp_o,
  // Far side, request direction
  output logic [LOG_DEPTH:0]            req_wptr_o,
  output logic [REQ_DATA_W-1:0]         req_data_o,
  input  logic [LOG_DEPTH:0]            req_rptr_i,
  // Far side, response direction
  input  logic [LOG_DEPTH:0]            rsp_wptr_i,
  input  logic [RSP_DATA_W-1:0]         rsp_data_i,
  output logic [LOG_DEPTH:0]            rsp_rptr_o,
  // Status
  output logic                          overflow_o,
  output logic [cdc_pkg::ERR_CNT_W-1:0] err_cnt_o
);
  import cdc_pkg::*;

  // ******************************
  // Request crossing
  // ******************************
  cdc_src_half #(
    .LOG_DEPTH ( LOG_DEPTH ),
    .payload_t ( req_t     )
  ) i_req_src (
    .clk_i      ( clk_i       ),
    .rst_n_i    ( rst_n_i     ),
    .push_i     ( req_valid_i ),
    .payload_i  ( req_i       ),
    .wptr_o     ( req_wptr_o  ),
    .data_o     ( req_data_o  ),
    .rptr_i     ( req_rptr_i  ),
    .overflow_o ( overflow_o  )
  );

  // ******************************
  // Response crossing
  // ******************************
  cdc_dst_half #(
    .LOG_DEPTH ( LOG_DEPTH ),
    .payload_t ( rsp_t     )
  ) i_rsp_dst (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .wptr_i      ( rsp_wptr_i  ),
    .data_i      ( rsp_data_i  ),
    .rptr_o      ( rsp_rptr_o  ),
    .pop_valid_o ( rsp_valid_o ),
    .payload_o   ( rsp_o       )
  );

  // Watches the same responses the core takes
  resp_err_counter #(
    .ERR_CNT_W ( ERR_CNT_W )
  ) i_err_cnt (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .rsp_valid_i ( rsp_valid_o ),
    .resp_i      ( rsp_o.resp  ),
    .err_cnt_o   ( err_cnt_o   )
  );

endmodule

/* resp_err_counter.sv */
// Saturating count of delivered responses carrying SLVERR or DECERR
`timescale 1ns/1ps

module resp_err_counter #(
  parameter int unsigned ERR_CNT_W = cdc_pkg::ERR_CNT_W
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       rsp_valid_i,
  input  logic [cdc_pkg::RESP_W-1:0] resp_i,
  output logic [ERR_CNT_W-1:0]       err_cnt_o
);
  import cdc_pkg::*;

  logic [ERR_CNT_W-1:0] cnt_q;
  logic                 is_err;
  logic                 at_max;

  // Only the two error codes count
  assign is_err = rsp_valid_i && ((resp_i == RESP_SLVERR) || (resp_i == RESP_DECERR));
  assign at_max = &cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (is_err && !at_max) begin
      cnt_q <= cnt_q + ERR_CNT_W'(1);
    end
  end

  assign err_cnt_o = cnt_q;

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f build.f -o sim

./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
  exit 1
fi
if ! grep -q "All checks passed" sim.log; then
  exit 1
fi

/* tb_checker.sv */
// Testbench checker for one master port that predicts its traffic and counts mismatches
`timescale 1ns/1ps

module tb_checker #(
  parameter string       NAME      = "data",
  parameter int unsigned LOG_DEPTH = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_valid_i,
  input  cdc_pkg::req_t                 req_i,
  input  logic                          far_pop_i,
  input  cdc_pkg::req_t                 far_req_i,
  input  logic                          far_rsp_wr_i,
  input  cdc_pkg::rsp_t                 far_rsp_i,
  input  logic                          rsp_valid_i,
  input  cdc_pkg::rsp_t                 rsp_i,
  input  logic [LOG_DEPTH:0]            req_wptr_i,
  input  logic [LOG_DEPTH:0]            rsp_rptr_i,
  input  logic                          overflow_i,
  input  logic [cdc_pkg::ERR_CNT_W-1:0] err_cnt_i,
  input  logic                          end_i,
  output int                            errors_o
);
  import cdc_pkg::*;

  localparam int DEPTH   = 2**LOG_DEPTH;
  localparam int ERR_MAX = 2**ERR_CNT_W - 1;

  req_t     exp_req [$];
  rsp_t     exp_rsp [$];
  int       occ;
  logic [1:0] credit;
  logic     exp_ovf;
  int       exp_err;
  int       errors      = 0;
  int       rst_cycles  = 0;
  req_t     want_req;
  rsp_t     want_rsp;

  // ******************************
  // Reference model
  // ******************************
  // A push is kept only while fewer than DEPTH entries are outstanding
  function automatic bit push_fits(input int outstanding);
    return outstanding < DEPTH;
  endfunction

  // SLVERR and DECERR count up to the counter maximum
  function automatic int next_err_count(input int cnt, input logic [1:0] code);
    if ((code == 2'd2 || code == 2'd3) && cnt < ERR_MAX) begin
      return cnt + 1;
    end
    return cnt;
  endfunction

  assign errors_o = errors;

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      rst_cycles++;
      occ     = 0;
      credit  = '0;
      exp_ovf = 1'b0;
      exp_err = 0;
      exp_req.delete();
      exp_rsp.delete();
      // Outputs settle one edge into reset
      if (rst_cycles > 1 && (req_wptr_i !== '0 || rsp_rptr_i !== '0 || rsp_valid_i !== 1'b0 ||
                             overflow_i !== 1'b0 || err_cnt_i !== '0)) begin
        $write("Error: %s reset exp 0 got req_wptr_o %h rsp_rptr_o %h ", NAME,
               req_wptr_i, rsp_rptr_i);
        $display("rsp_valid_o %h overflow_o %h err_cnt_o %h", rsp_valid_i, overflow_i,
                 err_cnt_i);
        errors++;
      end
    end else begin
      rst_cycles = 0;
      if (err_cnt_i !== ERR_CNT_W'(exp_err)) begin
        $display("Error: %s_err_cnt_o exp %h got %h", NAME, ERR_CNT_W'(exp_err), err_cnt_i);
        errors++;
      end
      if (overflow_i !== exp_ovf) begin
        $display("Error: %s_overflow_o exp %h got %h", NAME, exp_ovf, overflow_i);
        errors++;
      end
      // Far pops free space three samples later through the two-flop synchronizer
      occ    = occ - int'(credit[1]);
      credit = {credit[0], far_pop_i};
      if (req_valid_i) begin
        if (push_fits(occ)) begin
          exp_req.push_back(req_i);
          occ++;
        end else begin
          exp_ovf = 1'b1;
        end
      end
      if (far_pop_i) begin
        if (exp_req.size() == 0) begin
          $display("%s port: far side received a request that was never accepted", NAME);
          errors++;
        end else begin
          want_req = exp_req.pop_front();
          if (far_req_i !== want_req) begin
            $display("Error: %s_req_data_o exp %h got %h", NAME, want_req, far_req_i);
            errors++;
          end
        end
      end
      if (far_rsp_wr_i) begin
        exp_rsp.push_back(far_rsp_i);
      end
      if (rsp_valid_i) begin
        if (exp_rsp.size() == 0) begin
          $display("%s port: response delivered with none outstanding", NAME);
          errors++;
        end else begin
          want_rsp = exp_rsp.pop_front();
          if (rsp_i !== want_rsp) begin
            $display("Error: %s_rsp_o exp %h got %h", NAME, want_rsp, rsp_i);
            errors++;
          end
          exp_err = next_err_count(exp_err, want_rsp.resp);
        end
      end
      if (end_i && (exp_req.size() != 0 || exp_rsp.size() != 0)) begin
        $display("%s port: %0d requests and %0d responses never arrived", NAME,
                 exp_req.size(), exp_rsp.size());
        errors++;
      end
    end
  end

endmodule

/* tb_top.sv */
// Testbench top with clock, reset, stimulus, far-domain FIFO model and closing report
`timescale 1ns/1ps

module tb_top;
  import cdc_pkg::*;

  localparam int unsigned LOG_DEPTH  = 2;
  localparam int          DEPTH      = 2**LOG_DEPTH;
  localparam int          REQ_W      = $bits(req_t);
  localparam int          RSP_W      = $bits(rsp_t);
  localparam int          RAND_N     = 30;
  localparam int          NUM_TXN    = 8 + 8 + 4*RAND_N + 6;
  localparam int          MAX_CYCLES = NUM_TXN*20 + 200;

  typedef logic [LOG_DEPTH:0] ptr_t;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   req_valid [2];
  req_t                   req [2];
  logic                   rsp_valid [2];
  rsp_t                   rsp [2];
  ptr_t                   req_wptr [2];
  ptr_t                   req_rptr [2];
  ptr_t                   rsp_wptr [2];
  ptr_t                   rsp_rptr [2];
  logic [DEPTH*REQ_W-1:0] req_data [2];
  logic [DEPTH*RSP_W-1:0] rsp_data [2];
  logic                   overflow [2];
  logic [ERR_CNT_W-1:0]   err_cnt [2];
  // Far-domain model state
  rsp_t                   rsp_mem [2][DEPTH];
  ptr_t                   req_rbin [2];
  ptr_t                   rsp_wbin [2];
  logic                   req_stall [2];
  logic                   far_pop [2];
  logic                   far_rsp_wr [2];
  req_t                   far_req [2];
  rsp_t                   far_rsp [2];
  int                     req_seen [2];
  int                     req_issued [2];
  int                     rsp_sent [2];
  int                     rsp_got [2];
  int                     errors [2];
  int                     assert_fails;
  logic                   end_chk;
  int                     cycles;

  function automatic ptr_t gray_of(input ptr_t b);
    return b ^ (b >> 1);
  endfunction

  function automatic ptr_t bin_of(input ptr_t g);
    ptr_t b;
    b[LOG_DEPTH] = g[LOG_DEPTH];
    for (int i = LOG_DEPTH-1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  core_cdc_wrap #(.LOG_DEPTH(LOG_DEPTH)) dut0 (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .data_req_valid_i (req_valid[0]), .data_req_i (req[0]),
    .data_rsp_valid_o (rsp_valid[0]), .data_rsp_o (rsp[0]),
    .data_req_wptr_o (req_wptr[0]), .data_req_data_o (req_data[0]),
    .data_req_rptr_i (req_rptr[0]), .data_rsp_wptr_i (rsp_wptr[0]),
    .data_rsp_data_i (rsp_data[0]), .data_rsp_rptr_o (rsp_rptr[0]),
    .data_overflow_o (overflow[0]), .data_err_cnt_o (err_cnt[0]),
    .cfi_req_valid_i (req_valid[1]), .cfi_req_i (req[1]),
    .cfi_rsp_valid_o (rsp_valid[1]), .cfi_rsp_o (rsp[1]),
    .cfi_req_wptr_o (req_wptr[1]), .cfi_req_data_o (req_data[1]),
    .cfi_req_rptr_i (req_rptr[1]), .cfi_rsp_wptr_i (rsp_wptr[1]),
    .cfi_rsp_data_i (rsp_data[1]), .cfi_rsp_rptr_o (rsp_rptr[1]),
    .cfi_overflow_o (overflow[1]), .cfi_err_cnt_o (err_cnt[1])
  );

  for (genvar p = 0; p < 2; p++) begin : g_chk
    tb_checker #(.NAME(p == 0 ? "data" : "cfi"), .LOG_DEPTH(LOG_DEPTH)) chk (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .req_valid_i (req_valid[p]), .req_i (req[p]),
      .far_pop_i (far_pop[p]), .far_req_i (far_req[p]),
      .far_rsp_wr_i (far_rsp_wr[p]), .far_rsp_i (far_rsp[p]),
      .rsp_valid_i (rsp_valid[p]), .rsp_i (rsp[p]),
      .req_wptr_i (req_wptr[p]), .rsp_rptr_i (rsp_rptr[p]),
      .overflow_i (overflow[p]), .err_cnt_i (err_cnt[p]),
      .end_i (end_chk), .errors_o (errors[p])
    );
    assign req_rptr[p] = gray_of(req_rbin[p]);
    assign rsp_wptr[p] = gray_of(rsp_wbin[p]);
    for (genvar k = 0; k < DEPTH; k++) begin : g_flat
      assign rsp_data[p][k*RSP_W +: RSP_W] = rsp_mem[p][k];
    end
  end

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ******************************
  // Far-domain request reader
  // ******************************
  always @(posedge clk_i) begin
    #2;
    for (int p = 0; p < 2; p++) begin
      far_pop[p] = 1'b0;
      if (!rst_n_i) begin
        req_rbin[p] = '0;
      end else if (!req_stall[p] && req_wptr[p] != gray_of(req_rbin[p])) begin
        far_req[p] = req_t'(req_data[p][req_rbin[p][LOG_DEPTH-1:0]*REQ_W +: REQ_W]);
        far_pop[p] = 1'b1;
        req_rbin[p] = req_rbin[p] + ptr_t'(1);
        req_seen[p]++;
      end
      if (rsp_valid[p]) begin
        rsp_got[p]++;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Checks failed");
    $finish;
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    for (int p = 0; p < 2; p++) begin
      req_valid[p]  = 1'b0;
      far_rsp_wr[p] = 1'b0;
    end
  endtask

  // Address bit 31 tags the port so cross-talk shows as a payload mismatch
  task automatic issue_req(input int p);
    req[p].addr  = ($urandom() & 32'h7fff_ffff) | (p == 1 ? 32'h8000_0000 : 32'h0);
    req[p].wdata = $urandom();
    req[p].we    = 1'($urandom());
    req[p].id    = ID_W'($urandom());
    req_valid[p] = 1'b1;
    req_issued[p]++;
  endtask

  function automatic bit rsp_room(input int p);
    return int'(ptr_t'(rsp_wbin[p] - bin_of(rsp_rptr[p]))) < DEPTH;
  endfunction

  task automatic write_rsp(input int p, input logic [1:0] code);
    rsp_t r;
    r.id    = ID_W'($urandom());
    r.rdata = $urandom();
    r.resp  = code;
    rsp_mem[p][rsp_wbin[p][LOG_DEPTH-1:0]] = r;
    rsp_wbin[p]   = rsp_wbin[p] + ptr_t'(1);
    far_rsp[p]    = r;
    far_rsp_wr[p] = 1'b1;
    rsp_sent[p]++;
  endtask

  // Idle until both crossings are empty on four cycles in a row
  task automatic drain();
    int stable;
    stable = 0;
    while (stable < 4) begin
      next_cycle();
      if (req_wptr[0] == gray_of(req_rbin[0]) && req_wptr[1] == gray_of(req_rbin[1]) &&
          rsp_got[0] == rsp_sent[0] && rsp_got[1] == rsp_sent[1]) begin
        stable++;
      end else begin
        stable = 0;
      end
    end
  endtask

  task automatic random_traffic();
    int nreq [2];
    int nrsp [2];
    nreq = '{0, 0};
    nrsp = '{0, 0};
    while (nreq[0] < RAND_N || nreq[1] < RAND_N || nrsp[0] < RAND_N || nrsp[1] < RAND_N) begin
      next_cycle();
      for (int p = 0; p < 2; p++) begin
        if (nreq[p] < RAND_N && req_issued[p] == req_seen[p] && $urandom() % 2 == 0) begin
          issue_req(p);
          nreq[p]++;
        end
        if (nrsp[p] < RAND_N && rsp_room(p) && $urandom() % 2 == 0) begin
          write_rsp(p, 2'($urandom()));
          nrsp[p]++;
        end
      end
    end
  endtask

  initial begin
    void'($urandom(32036));
    rst_n_i = 1'b0;
    end_chk = 1'b0;
    for (int p = 0; p < 2; p++) begin
      req_valid[p] = 1'b0;
      req[p] = '0;
      req_stall[p] = 1'b0;
      far_pop[p] = 1'b0;
      far_rsp_wr[p] = 1'b0;
      far_req[p] = '0;
      far_rsp[p] = '0;
      req_rbin[p] = '0;
      rsp_wbin[p] = '0;
      req_seen[p] = 0;
      req_issued[p] = 0;
      rsp_sent[p] = 0;
      rsp_got[p] = 0;
      for (int k = 0; k < DEPTH; k++) begin
        rsp_mem[p][k] = '0;
      end
    end
    repeat (10) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    // Directed requests with the far side keeping up
    for (int i = 0; i < 8; i++) begin
      next_cycle();
      issue_req(0);
      next_cycle();
    end
    // Directed responses over all four codes
    for (int i = 0; i < 8; i++) begin
      next_cycle();
      while (!rsp_room(0)) begin
        next_cycle();
      end
      write_rsp(0, 2'(i));
    end
    drain();
    random_traffic();
    drain();
    // Far side stalls while six pushes meet a four-entry FIFO
    req_stall[0] = 1'b1;
    for (int i = 0; i < 6; i++) begin
      next_cycle();
      issue_req(0);
    end
    next_cycle();
    req_stall[0] = 1'b0;
    drain();
    end_chk = 1'b1;
    next_cycle();
    end_chk = 1'b0;
    next_cycle();
    assert_fails = dut0.data_port.u_chk.fail_cnt + dut0.cfi_port.u_chk.fail_cnt;
    $display("Error count: data %0d, cfi %0d, assertions %0d", errors[0], errors[1],
             assert_fails);
    if (errors[0] + errors[1] + assert_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
